// File: rtl/tile_mem_pkg.sv
// Memory geometry of the tile
// Word count, word width and byte enables of the single SRAM bank,
// plus the vector types that carry them between the blocks

`default_nettype none

package tile_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bank geometry
  ////////////////////////////////////////////////////////////////////////////

  // 256 words of 128 bits, 4 KiB in total
  localparam int unsigned MemNumWords  = 256;
  localparam int unsigned MemDataWidth = 128;
  localparam int unsigned MemBeWidth   = MemDataWidth / 8;
  localparam int unsigned MemAddrWidth = $clog2(MemNumWords);

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  // Word index into the bank
  typedef logic [MemAddrWidth-1:0] mem_addr_t;

  // One full memory word
  typedef logic [MemDataWidth-1:0] mem_data_t;

  // One enable per byte of a word
  typedef logic [MemBeWidth-1:0] mem_be_t;

endpackage

`default_nettype wire

// File: rtl/tile_port_pkg.sv
// Port-side definitions of the tile
// Narrow port widths, lane and burst fields, and the FSM encodings

`default_nettype none

package tile_port_pkg;

  // Narrow port carries one 32-bit word, addressed by byte
  localparam int unsigned NarrowDataWidth = 32;
  localparam int unsigned NarrowAddrWidth = 12;
  localparam int unsigned NumLanes        = 4;

  typedef logic [NarrowDataWidth-1:0]   narrow_data_t;
  typedef logic [NarrowDataWidth/8-1:0] narrow_be_t;
  typedef logic [NarrowAddrWidth-1:0]   narrow_addr_t;

  // Which 32-bit lane of a memory word
  typedef logic [$clog2(NumLanes)-1:0] lane_t;

  // Beats minus one, so up to 4 beats
  typedef logic [1:0] burst_len_t;

  // Wide burst unit FSM
  typedef enum logic {
    BurstIdle,
    BurstActive
  } burst_state_e;

  // Port that a bank slot belongs to
  typedef enum logic {
    OwnNarrow,
    OwnWide
  } owner_e;

endpackage

`default_nettype wire

// File: rtl/narrow_lane_adapter.sv
// Narrow port lane adapter
// Maps 32-bit accesses onto one lane of a 128-bit word and returns
// the addressed lane of the read word one cycle after the grant

`timescale 1ns/1ns
`default_nettype none

module narrow_lane_adapter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Narrow port
  input  logic                        narrow_req_i,
  input  logic                        narrow_we_i,
  input  tile_port_pkg::narrow_addr_t narrow_addr_i,
  input  tile_port_pkg::narrow_data_t narrow_wdata_i,
  input  tile_port_pkg::narrow_be_t   narrow_be_i,
  output logic                        narrow_gnt_o,
  output logic                        narrow_rvalid_o,
  output tile_port_pkg::narrow_data_t narrow_rdata_o,
  // Toward the arbiter
  output logic                        bank_req_o,
  output logic                        bank_we_o,
  output tile_mem_pkg::mem_addr_t     bank_addr_o,
  output tile_mem_pkg::mem_data_t     bank_wdata_o,
  output tile_mem_pkg::mem_be_t       bank_be_o,
  input  logic                        bank_gnt_i,
  input  logic                        bank_rvalid_i,
  input  tile_mem_pkg::mem_data_t     bank_rdata_i
);

  tile_port_pkg::lane_t lane;
  tile_port_pkg::lane_t lane_q;

  // Byte offset sits in bits 1:0, lane in 3:2, word index above
  assign lane        = narrow_addr_i[3:2];
  assign bank_addr_o = narrow_addr_i[tile_port_pkg::NarrowAddrWidth-1 -: tile_mem_pkg::MemAddrWidth];
  assign bank_req_o  = narrow_req_i;
  assign bank_we_o   = narrow_we_i;
  assign narrow_gnt_o = bank_gnt_i;

  // Data goes to every lane, enables only to the addressed one
  always_comb begin
    for (int l = 0; l < tile_port_pkg::NumLanes; l++) begin
      bank_wdata_o[l*tile_port_pkg::NarrowDataWidth +: tile_port_pkg::NarrowDataWidth] =
        narrow_wdata_i;
      bank_be_o[l*(tile_port_pkg::NarrowDataWidth/8) +: tile_port_pkg::NarrowDataWidth/8] =
        (lane == tile_port_pkg::lane_t'(l)) ? narrow_be_i : '0;
    end
  end

  // Remember the lane of the access now in the bank
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lane_q <= '0;
    end else if (bank_req_o && bank_gnt_i) begin
      lane_q <= lane;
    end
  end

  assign narrow_rvalid_o = bank_rvalid_i;
  assign narrow_rdata_o  =
    bank_rdata_i[lane_q*tile_port_pkg::NarrowDataWidth +: tile_port_pkg::NarrowDataWidth];

  // Response only for an access granted the cycle before
  a_rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (reset_i)
    bank_rvalid_i |-> $past(bank_req_o && bank_gnt_i)
  );

endmodule

`default_nettype wire

// File: rtl/wide_burst_unit.sv
// Wide port burst unit
// Turns a wide command into one bank request per beat and flags the
// response of the last beat

`timescale 1ns/1ns
`default_nettype none

module wide_burst_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Wide port
  input  logic                      wide_req_i,
  input  logic                      wide_we_i,
  input  tile_mem_pkg::mem_addr_t   wide_addr_i,
  input  tile_port_pkg::burst_len_t wide_len_i,
  input  tile_mem_pkg::mem_data_t   wide_wdata_i,
  input  tile_mem_pkg::mem_be_t     wide_be_i,
  output logic                      wide_gnt_o,
  output logic                      wide_rlast_o,
  // Toward the arbiter
  output logic                      bank_req_o,
  output logic                      bank_we_o,
  output tile_mem_pkg::mem_addr_t   bank_addr_o,
  output tile_mem_pkg::mem_data_t   bank_wdata_o,
  output tile_mem_pkg::mem_be_t     bank_be_o,
  input  logic                      bank_gnt_i,
  input  logic                      bank_rvalid_i
);

  tile_port_pkg::burst_state_e state_q;
  tile_mem_pkg::mem_addr_t     addr_q;
  tile_port_pkg::burst_len_t   remain_q;
  logic                        is_idle;
  logic                        beat_last;
  logic                        last_q;

  assign is_idle = (state_q == tile_port_pkg::BurstIdle);

  ////////////////////////////////////////////////////////////////////////////
  // Beat issue
  ////////////////////////////////////////////////////////////////////////////

  // First beat straight from the command, later beats from the counter
  assign bank_req_o   = is_idle ? wide_req_i : 1'b1;
  assign bank_we_o    = is_idle ? wide_we_i : 1'b0;
  assign bank_addr_o  = is_idle ? wide_addr_i : addr_q;
  assign bank_wdata_o = wide_wdata_i;
  assign bank_be_o    = is_idle ? wide_be_i : '0;
  assign beat_last    = is_idle ? (wide_we_i || wide_len_i == '0) : (remain_q == '0);

  // Command accepted together with its first beat
  assign wide_gnt_o = is_idle && (bank_gnt_i || !wide_req_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= tile_port_pkg::BurstIdle;
      addr_q   <= '0;
      remain_q <= '0;
      last_q   <= 1'b0;
    end else begin
      last_q <= bank_req_o && bank_gnt_i && beat_last;
      if (bank_req_o && bank_gnt_i) begin
        if (is_idle) begin
          if (!beat_last) begin
            state_q  <= tile_port_pkg::BurstActive;
            addr_q   <= wide_addr_i + 1'b1;
            remain_q <= wide_len_i - 1'b1;
          end
        end else begin
          // Address wraps from 255 to 0 on its own
          addr_q   <= addr_q + 1'b1;
          remain_q <= remain_q - 1'b1;
          if (beat_last) begin
            state_q <= tile_port_pkg::BurstIdle;
          end
        end
      end
    end
  end

  assign wide_rlast_o = bank_rvalid_i && last_q;

  a_write_single_beat: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (wide_req_i && wide_gnt_o && wide_we_i) |-> (wide_len_i == '0)
  );

  // A multi-beat read holds off the next command
  a_no_gnt_in_burst: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (wide_req_i && wide_gnt_o && !wide_we_i && wide_len_i != '0) |=> !wide_gnt_o
  );

endmodule

`default_nettype wire

// File: rtl/bank_arbiter.sv
// Bank arbiter
// Round-robin choice between the narrow and wide request streams,
// with the read response steered back to the stream that won

`timescale 1ns/1ns
`default_nettype none

module bank_arbiter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Narrow stream
  input  logic                    n_req_i,
  input  logic                    n_we_i,
  input  tile_mem_pkg::mem_addr_t n_addr_i,
  input  tile_mem_pkg::mem_data_t n_wdata_i,
  input  tile_mem_pkg::mem_be_t   n_be_i,
  output logic                    n_gnt_o,
  output logic                    n_rvalid_o,
  // Wide stream
  input  logic                    w_req_i,
  input  logic                    w_we_i,
  input  tile_mem_pkg::mem_addr_t w_addr_i,
  input  tile_mem_pkg::mem_data_t w_wdata_i,
  input  tile_mem_pkg::mem_be_t   w_be_i,
  output logic                    w_gnt_o,
  output logic                    w_rvalid_o,
  // Bank side
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output tile_mem_pkg::mem_addr_t mem_addr_o,
  output tile_mem_pkg::mem_data_t mem_wdata_o,
  output tile_mem_pkg::mem_be_t   mem_be_o
);

  tile_port_pkg::owner_e last_q;
  tile_port_pkg::owner_e owner_q;
  logic                  owner_vld_q;
  logic                  pick_wide;

  // Wide wins alone, or in a contest that narrow won last time
  assign pick_wide = w_req_i && (!n_req_i || last_q == tile_port_pkg::OwnNarrow);

  assign w_gnt_o = pick_wide;
  assign n_gnt_o = n_req_i && !pick_wide;

  assign mem_req_o   = n_req_i || w_req_i;
  assign mem_we_o    = pick_wide ? w_we_i : n_we_i;
  assign mem_addr_o  = pick_wide ? w_addr_i : n_addr_i;
  assign mem_wdata_o = pick_wide ? w_wdata_i : n_wdata_i;
  assign mem_be_o    = pick_wide ? w_be_i : n_be_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Narrow takes the first contest
      last_q      <= tile_port_pkg::OwnWide;
      owner_q     <= tile_port_pkg::OwnNarrow;
      owner_vld_q <= 1'b0;
    end else begin
      if (n_req_i && w_req_i) begin
        last_q <= pick_wide ? tile_port_pkg::OwnWide : tile_port_pkg::OwnNarrow;
      end
      owner_q     <= pick_wide ? tile_port_pkg::OwnWide : tile_port_pkg::OwnNarrow;
      owner_vld_q <= mem_req_o;
    end
  end

  assign n_rvalid_o = owner_vld_q && (owner_q == tile_port_pkg::OwnNarrow);
  assign w_rvalid_o = owner_vld_q && (owner_q == tile_port_pkg::OwnWide);

  // Back-to-back contests alternate the winner
  a_alternate: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (!$past(reset_i) && n_req_i && w_req_i && $past(n_req_i && w_req_i))
      |-> (w_gnt_o == $past(n_gnt_o))
  );

endmodule

`default_nettype wire

// File: rtl/sram_bank.sv
// Single-port SRAM bank
// Byte-enabled writes, read data registered one cycle after the request

`timescale 1ns/1ns
`default_nettype none

module sram_bank (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  tile_mem_pkg::mem_addr_t addr_i,
  input  tile_mem_pkg::mem_data_t wdata_i,
  input  tile_mem_pkg::mem_be_t   be_i,
  output tile_mem_pkg::mem_data_t rdata_o
);

  tile_mem_pkg::mem_data_t mem_q [tile_mem_pkg::MemNumWords];

  ////////////////////////////////////////////////////////////////////////////
  // Storage array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < tile_mem_pkg::MemBeWidth; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_tile.sv
// Memory tile top level
// Narrow and wide request ports sharing one SRAM bank through a
// round-robin arbiter

`timescale 1ns/1ns
`default_nettype none

module mem_tile (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Narrow port
  input  logic                        narrow_req_i,
  input  logic                        narrow_we_i,
  input  tile_port_pkg::narrow_addr_t narrow_addr_i,
  input  tile_port_pkg::narrow_data_t narrow_wdata_i,
  input  tile_port_pkg::narrow_be_t   narrow_be_i,
  output logic                        narrow_gnt_o,
  output logic                        narrow_rvalid_o,
  output tile_port_pkg::narrow_data_t narrow_rdata_o,
  // Wide port
  input  logic                        wide_req_i,
  input  logic                        wide_we_i,
  input  tile_mem_pkg::mem_addr_t     wide_addr_i,
  input  tile_port_pkg::burst_len_t   wide_len_i,
  input  tile_mem_pkg::mem_data_t     wide_wdata_i,
  input  tile_mem_pkg::mem_be_t       wide_be_i,
  output logic                        wide_gnt_o,
  output logic                        wide_rvalid_o,
  output logic                        wide_rlast_o,
  output tile_mem_pkg::mem_data_t     wide_rdata_o
);

  logic                    n_req, n_we, n_gnt, n_rvalid;
  tile_mem_pkg::mem_addr_t n_addr;
  tile_mem_pkg::mem_data_t n_wdata;
  tile_mem_pkg::mem_be_t   n_be;

  logic                    w_req, w_we, w_gnt, w_rvalid;
  tile_mem_pkg::mem_addr_t w_addr;
  tile_mem_pkg::mem_data_t w_wdata;
  tile_mem_pkg::mem_be_t   w_be;

  logic                    mem_req, mem_we;
  tile_mem_pkg::mem_addr_t mem_addr;
  tile_mem_pkg::mem_data_t mem_wdata, mem_rdata;
  tile_mem_pkg::mem_be_t   mem_be;

  ////////////////////////////////////////////////////////////////////////////
  // Port units
  ////////////////////////////////////////////////////////////////////////////

  narrow_lane_adapter u_narrow (
    .clk_i, .reset_i,
    .narrow_req_i, .narrow_we_i, .narrow_addr_i, .narrow_wdata_i, .narrow_be_i,
    .narrow_gnt_o, .narrow_rvalid_o, .narrow_rdata_o,
    .bank_req_o    ( n_req     ),
    .bank_we_o     ( n_we      ),
    .bank_addr_o   ( n_addr    ),
    .bank_wdata_o  ( n_wdata   ),
    .bank_be_o     ( n_be      ),
    .bank_gnt_i    ( n_gnt     ),
    .bank_rvalid_i ( n_rvalid  ),
    .bank_rdata_i  ( mem_rdata )
  );

  wide_burst_unit u_wide (
    .clk_i, .reset_i,
    .wide_req_i, .wide_we_i, .wide_addr_i, .wide_len_i, .wide_wdata_i, .wide_be_i,
    .wide_gnt_o, .wide_rlast_o,
    .bank_req_o    ( w_req    ),
    .bank_we_o     ( w_we     ),
    .bank_addr_o   ( w_addr   ),
    .bank_wdata_o  ( w_wdata  ),
    .bank_be_o     ( w_be     ),
    .bank_gnt_i    ( w_gnt    ),
    .bank_rvalid_i ( w_rvalid )
  );

  // Wide responses come straight from arbiter and bank
  assign wide_rvalid_o = w_rvalid;
  assign wide_rdata_o  = mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Arbiter and bank
  ////////////////////////////////////////////////////////////////////////////

  bank_arbiter u_arb (
    .clk_i, .reset_i,
    .n_req_i ( n_req ), .n_we_i ( n_we ), .n_addr_i ( n_addr ),
    .n_wdata_i ( n_wdata ), .n_be_i ( n_be ),
    .n_gnt_o ( n_gnt ), .n_rvalid_o ( n_rvalid ),
    .w_req_i ( w_req ), .w_we_i ( w_we ), .w_addr_i ( w_addr ),
    .w_wdata_i ( w_wdata ), .w_be_i ( w_be ),
    .w_gnt_o ( w_gnt ), .w_rvalid_o ( w_rvalid ),
    .mem_req_o   ( mem_req   ),
    .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata ),
    .mem_be_o    ( mem_be    )
  );

  sram_bank u_bank (
    .clk_i,
    .req_i   ( mem_req   ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .be_i    ( mem_be    ),
    .rdata_o ( mem_rdata )
  );

endmodule

`default_nettype wire

// File: dv/mem_tile_tb.sv
// Memory tile testbench
// Applies a table of narrow and wide operations and checks every grant and
// response against a reference memory and a model of the bank arbitration

`timescale 1ns/1ns
`default_nettype none

module mem_tile_tb;

  localparam int ClkPeriod  = 100;
  localparam int NumOps     = 16;
  localparam int Seed       = 38070;
  localparam int WdogMargin = 40;

  localparam bit [1:0] OpNone = 2'd0;
  localparam bit [1:0] OpRd   = 2'd1;
  localparam bit [1:0] OpWr   = 2'd2;

  typedef logic [127:0] val_t;

  logic                        clk_i;
  logic                        reset_i;
  logic                        narrow_req_i;
  logic                        narrow_we_i;
  tile_port_pkg::narrow_addr_t narrow_addr_i;
  tile_port_pkg::narrow_data_t narrow_wdata_i;
  tile_port_pkg::narrow_be_t   narrow_be_i;
  logic                        narrow_gnt_o;
  logic                        narrow_rvalid_o;
  tile_port_pkg::narrow_data_t narrow_rdata_o;
  logic                        wide_req_i;
  logic                        wide_we_i;
  tile_mem_pkg::mem_addr_t     wide_addr_i;
  tile_port_pkg::burst_len_t   wide_len_i;
  tile_mem_pkg::mem_data_t     wide_wdata_i;
  tile_mem_pkg::mem_be_t       wide_be_i;
  logic                        wide_gnt_o;
  logic                        wide_rvalid_o;
  logic                        wide_rlast_o;
  tile_mem_pkg::mem_data_t     wide_rdata_o;

  // Operation table
  string                       op_name [NumOps];
  bit [1:0]                    n_op    [NumOps];
  tile_port_pkg::narrow_addr_t n_addr  [NumOps];
  tile_port_pkg::narrow_be_t   n_be    [NumOps];
  int                          n_dly   [NumOps];
  bit [1:0]                    w_op    [NumOps];
  tile_mem_pkg::mem_addr_t     w_addr  [NumOps];
  tile_port_pkg::burst_len_t   w_len   [NumOps];
  tile_mem_pkg::mem_be_t       w_be    [NumOps];

  // Reference model state
  tile_mem_pkg::mem_data_t     ref_mem [tile_mem_pkg::MemNumWords];
  bit                          last_wide;
  bit                          burst_active;
  tile_mem_pkg::mem_addr_t     burst_addr;
  int                          burst_remain;
  bit                          exp_n_vld;
  bit                          exp_n_rd;
  bit                          exp_w_vld;
  bit                          exp_w_rd;
  bit                          exp_w_last;
  tile_port_pkg::narrow_data_t exp_n_data;
  tile_mem_pkg::mem_data_t     exp_w_data;

  bit [31:0] lcg_state;
  int        errs;
  int        op_errs;
  int        tests_failed;

  mem_tile uut (.*);

  always #(ClkPeriod/2) clk_i = ~clk_i;

  function automatic bit [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic report_mismatch(string sig, val_t exp_v, val_t got_v);
    $display("Fail at %0t ns: %s expected %h, got %h", $time, sig, exp_v, got_v);
    errs++;
    op_errs++;
  endtask

  task automatic report_problem(string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errs++;
    op_errs++;
  endtask

  task automatic load_op(int i, string name, bit [1:0] nop, tile_port_pkg::narrow_addr_t na,
                         tile_port_pkg::narrow_be_t nbe, int ndly, bit [1:0] wop,
                         tile_mem_pkg::mem_addr_t wa, tile_port_pkg::burst_len_t wl,
                         tile_mem_pkg::mem_be_t wbe);
    op_name[i] = name;
    n_op[i]    = nop;
    n_addr[i]  = na;
    n_be[i]    = nbe;
    n_dly[i]   = ndly;
    w_op[i]    = wop;
    w_addr[i]  = wa;
    w_len[i]   = wl;
    w_be[i]    = wbe;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle check and model update, sampled at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_cycle(output bit n_acc, output bit w_acc);
    bit                      n_want;
    bit                      w_want;
    bit                      win_wide;
    tile_mem_pkg::mem_addr_t a;
    tile_port_pkg::lane_t    lane;
    // Responses due from last cycle's grants
    if (narrow_rvalid_o !== exp_n_vld) begin
      if (exp_n_vld)
        report_problem("narrow response missing one cycle after its grant");
      else
        report_mismatch("narrow_rvalid_o", val_t'(exp_n_vld), val_t'(narrow_rvalid_o));
    end else if (exp_n_rd && narrow_rdata_o !== exp_n_data) begin
      report_mismatch("narrow_rdata_o", val_t'(exp_n_data), val_t'(narrow_rdata_o));
    end
    if (wide_rvalid_o !== exp_w_vld) begin
      if (exp_w_vld)
        report_problem("wide response missing one cycle after its beat won the bank");
      else
        report_mismatch("wide_rvalid_o", val_t'(exp_w_vld), val_t'(wide_rvalid_o));
    end else if (exp_w_rd && wide_rdata_o !== exp_w_data) begin
      report_mismatch("wide_rdata_o", exp_w_data, wide_rdata_o);
    end
    if (wide_rlast_o !== (exp_w_vld && exp_w_last))
      report_mismatch("wide_rlast_o", val_t'(exp_w_vld && exp_w_last), val_t'(wide_rlast_o));

    // Round robin, narrow wins unless it took the last contest
    n_want   = narrow_req_i;
    w_want   = burst_active || wide_req_i;
    win_wide = w_want && (!n_want || !last_wide);
    n_acc    = n_want && !win_wide;
    w_acc    = wide_req_i && !burst_active && win_wide;
    if (narrow_gnt_o !== n_acc)
      report_mismatch("narrow_gnt_o", val_t'(n_acc), val_t'(narrow_gnt_o));
    if ((wide_req_i && wide_gnt_o) !== w_acc)
      report_mismatch("wide_gnt_o", val_t'(w_acc), val_t'(wide_gnt_o));
    if (narrow_gnt_o && wide_req_i && wide_gnt_o)
      report_problem("narrow and wide requests granted in the same cycle");
    if (burst_active && wide_gnt_o)
      report_problem("wide_gnt_o high while a burst is still running");

    if (n_want && w_want)
      last_wide = win_wide;
    exp_n_vld = n_acc;
    exp_w_vld = win_wide;
    exp_n_rd  = 1'b0;
    exp_w_rd  = 1'b0;
    if (n_acc) begin
      a    = tile_mem_pkg::mem_addr_t'(narrow_addr_i >> 4);
      lane = narrow_addr_i[3:2];
      if (narrow_we_i) begin
        for (int b = 0; b < tile_port_pkg::NarrowDataWidth / 8; b++) begin
          if (narrow_be_i[b])
            ref_mem[a][lane*32 + b*8 +: 8] = narrow_wdata_i[b*8 +: 8];
        end
      end else begin
        exp_n_rd   = 1'b1;
        exp_n_data = ref_mem[a][lane*32 +: 32];
      end
    end
    if (win_wide) begin
      if (burst_active) begin
        exp_w_rd     = 1'b1;
        exp_w_data   = ref_mem[burst_addr];
        exp_w_last   = (burst_remain == 0);
        burst_active = (burst_remain != 0);
        burst_addr   = burst_addr + 1'b1;
        burst_remain--;
      end else if (wide_we_i) begin
        for (int b = 0; b < tile_mem_pkg::MemBeWidth; b++) begin
          if (wide_be_i[b])
            ref_mem[wide_addr_i][b*8 +: 8] = wide_wdata_i[b*8 +: 8];
        end
        exp_w_last = 1'b1;
      end else begin
        exp_w_rd     = 1'b1;
        exp_w_data   = ref_mem[wide_addr_i];
        exp_w_last   = (wide_len_i == '0);
        burst_active = (wide_len_i != '0);
        burst_addr   = wide_addr_i + 1'b1;
        burst_remain = int'(wide_len_i) - 1;
      end
    end
  endtask

  // One table row, run until all its requests and responses are done
  task automatic run_op(int i);
    bit                          n_pend;
    bit                          w_pend;
    bit                          n_up;
    bit                          n_acc;
    bit                          w_acc;
    int                          cyc;
    tile_port_pkg::narrow_data_t n_data;
    tile_mem_pkg::mem_data_t     w_data;
    n_data = lcg_next();
    for (int k = 0; k < 4; k++)
      w_data[k*32 +: 32] = lcg_next();
    n_pend  = (n_op[i] != OpNone);
    w_pend  = (w_op[i] != OpNone);
    n_up    = 1'b0;
    cyc     = 0;
    op_errs = 0;
    if (w_pend) begin
      wide_req_i   <= 1'b1;
      wide_we_i    <= (w_op[i] == OpWr);
      wide_addr_i  <= w_addr[i];
      wide_len_i   <= w_len[i];
      wide_wdata_i <= w_data;
      wide_be_i    <= w_be[i];
    end
    while (n_pend || w_pend || burst_active || exp_n_vld || exp_w_vld) begin
      if (n_pend && !n_up && cyc == n_dly[i]) begin
        narrow_req_i   <= 1'b1;
        narrow_we_i    <= (n_op[i] == OpWr);
        narrow_addr_i  <= n_addr[i];
        narrow_wdata_i <= n_data;
        narrow_be_i    <= n_be[i];
        n_up = 1'b1;
      end
      @(negedge clk_i);
      check_cycle(n_acc, w_acc);
      @(posedge clk_i);
      cyc++;
      if (n_acc) begin
        narrow_req_i <= 1'b0;
        n_pend = 1'b0;
      end
      if (w_acc) begin
        wide_req_i <= 1'b0;
        w_pend = 1'b0;
      end
    end
    if (op_errs != 0)
      tests_failed++;
    $display("test %0d %s: %s", i + 1, op_name[i], (op_errs == 0) ? "passed" : "failed");
  endtask

  task automatic load_table();
    load_op(0,  "wide write word 16",     OpNone, 12'h000, 4'h0, 0, OpWr, 8'd16,  2'd0, 16'hffff);
    load_op(1,  "wide partial write 16",  OpNone, 12'h000, 4'h0, 0, OpWr, 8'd16,  2'd0, 16'h0ff0);
    load_op(2,  "wide read word 16",      OpNone, 12'h000, 4'h0, 0, OpRd, 8'd16,  2'd0, 16'h0000);
    load_op(3,  "narrow write lane 0",    OpWr,   12'h100, 4'hf, 0, OpNone, 8'd0, 2'd0, 16'h0000);
    load_op(4,  "narrow write lane 2",    OpWr,   12'h108, 4'h6, 0, OpNone, 8'd0, 2'd0, 16'h0000);
    load_op(5,  "narrow read lane 2",     OpRd,   12'h108, 4'hf, 0, OpNone, 8'd0, 2'd0, 16'h0000);
    load_op(6,  "wide read merged 16",    OpNone, 12'h000, 4'h0, 0, OpRd, 8'd16,  2'd0, 16'h0000);
    load_op(7,  "wide write word 254",    OpNone, 12'h000, 4'h0, 0, OpWr, 8'd254, 2'd0, 16'hffff);
    load_op(8,  "wide write word 255",    OpNone, 12'h000, 4'h0, 0, OpWr, 8'd255, 2'd0, 16'hffff);
    load_op(9,  "wide write word 0",      OpNone, 12'h000, 4'h0, 0, OpWr, 8'd0,   2'd0, 16'hffff);
    load_op(10, "wide write word 1",      OpNone, 12'h000, 4'h0, 0, OpWr, 8'd1,   2'd0, 16'hffff);
    load_op(11, "burst of 4 from 254",    OpNone, 12'h000, 4'h0, 0, OpRd, 8'd254, 2'd3, 16'h0000);
    load_op(12, "contest, narrow first",  OpWr,   12'h014, 4'hf, 0, OpWr, 8'd0,   2'd0, 16'hff00);
    load_op(13, "contest, wide second",   OpRd,   12'h014, 4'hf, 0, OpRd, 8'd1,   2'd0, 16'h0000);
    load_op(14, "narrow inside burst",    OpRd,   12'h108, 4'hf, 1, OpRd, 8'd254, 2'd3, 16'h0000);
    load_op(15, "burst then narrow",      OpWr,   12'h0f4, 4'h3, 0, OpRd, 8'd0,   2'd1, 16'h0000);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    narrow_req_i   = 1'b0;
    narrow_we_i    = 1'b0;
    narrow_addr_i  = '0;
    narrow_wdata_i = '0;
    narrow_be_i    = '0;
    wide_req_i     = 1'b0;
    wide_we_i      = 1'b0;
    wide_addr_i    = '0;
    wide_len_i     = '0;
    wide_wdata_i   = '0;
    wide_be_i      = '0;
    lcg_state      = Seed;
    errs           = 0;
    tests_failed   = 0;
    // Narrow takes the first contest after reset
    last_wide      = 1'b1;
    burst_active   = 1'b0;
    exp_n_vld      = 1'b0;
    exp_w_vld      = 1'b0;
    load_table();

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    // Idle outputs right after reset
    @(negedge clk_i);
    op_errs = 0;
    if (narrow_gnt_o !== 1'b0)
      report_mismatch("narrow_gnt_o", val_t'(1'b0), val_t'(narrow_gnt_o));
    if (narrow_rvalid_o !== 1'b0)
      report_mismatch("narrow_rvalid_o", val_t'(1'b0), val_t'(narrow_rvalid_o));
    if (wide_rvalid_o !== 1'b0)
      report_mismatch("wide_rvalid_o", val_t'(1'b0), val_t'(wide_rvalid_o));
    if (wide_rlast_o !== 1'b0)
      report_mismatch("wide_rlast_o", val_t'(1'b0), val_t'(wide_rlast_o));
    if (wide_gnt_o !== 1'b1)
      report_mismatch("wide_gnt_o", val_t'(1'b1), val_t'(wide_gnt_o));
    if (op_errs != 0)
      tests_failed++;
    $display("test 0 outputs after reset: %s", (op_errs == 0) ? "passed" : "failed");
    @(posedge clk_i);

    for (int i = 0; i < NumOps; i++)
      run_op(i);

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             NumOps + 1, NumOps + 1 - tests_failed, tests_failed, errs);
    if (errs == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(ClkPeriod * (NumOps * 20 + WdogMargin));
    $display("Timeout: the operation table did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/tile_mem_pkg.sv
rtl/tile_port_pkg.sv
rtl/narrow_lane_adapter.sv
rtl/wide_burst_unit.sv
rtl/bank_arbiter.sv
rtl/sram_bank.sv
rtl/mem_tile.sv
dv/mem_tile_tb.sv

// File: Makefile
# Verilator lint and simulation of the memory tile

VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := mem_tile_tb
RTL_TOP    := mem_tile
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
